/* src.f */
logic/arm_core_pkg.sv
logic/arm_decoder.sv
logic/arm_control.sv
logic/arm_alu_shifter.sv
logic/arm_load_align.sv
logic/arm_regfile.sv
logic/arm_core.sv
tests/arm_core_tb.sv

/* tests/arm_core_vectors.txt */
# M <addr> <word> preloads memory; W <addr> <size> <data> is one expected write, in order
# Size 0 byte, 1 half, 2 word; E <addr> is the final branch-to-self
M 000 E3A00C02 # MOV R0, #0x200
M 004 E3A014FF # MOV R1, #0xFF000000
M 008 E3A02034 # MOV R2, #0x34
M 00C E0813002 # ADD R3, R1, R2
M 010 E5803000 # STR R3, [R0]
M 014 E0424201 # SUB R4, R2, R1, LSL #4
M 018 E5804004 # STR R4, [R0, #4]
M 01C E2625C01 # RSB R5, R2, #0x100
M 020 E0256441 # EOR R6, R5, R1, ASR #8
M 024 E1867262 # ORR R7, R6, R2, ROR #4
M 028 E5806008 # STR R6, [R0, #8]
M 02C E580700C # STR R7, [R0, #12]
M 030 E1E08E21 # MVN R8, R1, LSR #28
M 034 E5808010 # STR R8, [R0, #16]
M 038 E3520034 # CMP R2, #0x34
M 03C 05802014 # STREQ R2, [R0, #20]
M 040 15801018 # STRNE R1, [R0, #24] not taken
M 044 E1520005 # CMP R2, R5
M 048 B5805018 # STRLT R5, [R0, #24]
M 04C 2580501C # STRCS R5, [R0, #28] not taken
M 050 E3110102 # TST R1, #0x80000000
M 054 4580301C # STRMI R3, [R0, #28]
M 058 85802020 # STRHI R2, [R0, #32]
M 05C E3A09C03 # MOV R9, #0x300
M 060 E599A001 # LDR R10, [R9, #1]
M 064 E580A024 # STR R10, [R0, #36]
M 068 E5D9B002 # LDRB R11, [R9, #2]
M 06C E5C0B029 # STRB R11, [R0, #41]
M 070 E1D9C0B1 # LDRH R12, [R9, #1]
M 074 E580C02C # STR R12, [R0, #44]
M 078 E1D9C0F2 # LDRSH R12, [R9, #2]
M 07C E580C030 # STR R12, [R0, #48]
M 080 E1D9C0F1 # LDRSH R12, [R9, #1]
M 084 E580C034 # STR R12, [R0, #52]
M 088 E1D9C0D3 # LDRSB R12, [R9, #3]
M 08C E140C0B2 # STRH R12, [R0, #-2]
M 090 EA000000 # B 0x98
M 094 E5801038 # STR R1, [R0, #56] skipped
M 098 EB000002 # BL 0xA8
M 09C E580E03C # STR R14, [R0, #60]
M 0A0 EAFFFFFE # B .
M 0A8 E1A0F00E # MOV PC, R14
M 300 9A78F634 # load data
W 200 2 FF000034
W 204 2 10000034
W 208 2 FFFF00CC
W 20C 2 FFFF00CF
W 210 2 FFFFFFF0
W 214 2 00000034
W 218 2 000000CC
W 21C 2 FF000034
W 220 2 00000034
W 224 2 349A78F6
W 229 0 00000078
W 22C 2 000078F6
W 230 2 FFFF9A78
W 234 2 FFFFFFF6
W 1FE 1 0000FF9A
W 23C 2 0000009C
E 0A0

/* tests/arm_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_core_tb;
  import arm_core_pkg::*;

  localparam int FETCH_TIMEOUT = 16;  // Cycles allowed until the first fetch
  localparam int RUN_TIMEOUT = 2000;

  logic clk;
  logic reset;
  word_t rdata;
  word_t addr;
  logic rd_en;
  logic wr_en;
  logic fetch;
  mem_size_e size;
  word_t wdata;

  word_t mem [0:255];
  word_t exp_addr [$];
  word_t exp_size [$];
  word_t exp_data [$];
  word_t end_addr;
  int wr_count = 0;

  arm_core arm_core_i (
    .clk(clk),
    .reset(reset),
    .rdata(rdata),
    .addr(addr),
    .rd_en(rd_en),
    .wr_en(wr_en),
    .fetch(fetch),
    .size(size),
    .wdata(wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ======================================================================
  // Reporting
  // ======================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // ======================================================================
  // Memory image and vector file
  // ======================================================================
  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hF000_0000 | 32'(i);  // NV condition never executes
    end
  endtask

  task automatic load_vectors();
    int fd;
    int code;
    int ch;
    logic [7:0] kind;
    word_t f1, f2, f3;
    logic reading;
    fd = $fopen("tests/arm_core_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open tests/arm_core_vectors.txt");
    end else begin
      reading = 1'b1;
      while (reading) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          reading = 1'b0;
        end else if (kind == "#") begin
          ch = $fgetc(fd);  // Skip the rest of a comment
          while (ch != "\n" && ch != -1) ch = $fgetc(fd);
        end else if (kind == "M") begin
          code = $fscanf(fd, "%h %h", f1, f2);
          mem[f1[9:2]] = f2;
        end else if (kind == "W") begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          exp_addr.push_back(f1);
          exp_size.push_back(f2);
          exp_data.push_back(f3);
        end else if (kind == "E") begin
          code = $fscanf(fd, "%h", f1);
          end_addr = f1;
        end else begin
          abort_run($sformatf("Unknown line type '%c' in the vector file", kind));
        end
      end
      $fclose(fd);
    end
  endtask

  // ======================================================================
  // Bus writes
  // ======================================================================
  task automatic check_write();
    if (wr_count >= exp_addr.size()) begin
      abort_run($sformatf("Unexpected write to %h after the expected sequence", addr));
    end else begin
      check_value($sformatf("write %0d addr", wr_count), exp_addr[wr_count], addr);
      check_value($sformatf("write %0d size", wr_count), exp_size[wr_count], 32'(size));
      check_value($sformatf("write %0d data", wr_count), exp_data[wr_count], wdata);
    end
    wr_count++;
  endtask

  // Memory places byte lanes by addr[1:0]
  task automatic store_lanes();
    case (size)
      SIZE_BYTE: mem[addr[9:2]][{addr[1:0], 3'b000} +: 8] <= wdata[7:0];
      SIZE_HALF: mem[addr[9:2]][{addr[1], 4'b0000} +: 16] <= wdata[15:0];
      default: mem[addr[9:2]] <= wdata;
    endcase
  endtask

  always @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[addr[9:2]];  // Valid one cycle after the strobe
    end
    if (!reset) begin
      check_value("rd_en and wr_en together", 32'd0, 32'(rd_en && wr_en));
      check_value("fetch without rd_en", 32'd0, 32'(fetch && !rd_en));
      if (wr_en) begin
        check_write();
        store_lanes();
      end
    end
  end

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    int cycles;
    int end_hits;
    logic fetch_seen;
    reset = 1'b1;
    rdata = '0;
    fill_memory();
    load_vectors();

    // State is unknown before the first edge
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i > 0) check_value("wr_en during reset", 32'd0, 32'(wr_en));
    end
    reset <= 1'b0;

    cycles = 0;
    fetch_seen = 1'b0;
    while (!fetch_seen && cycles < FETCH_TIMEOUT) begin
      @(posedge clk);
      check_value("wr_en after reset", 32'd0, 32'(wr_en));
      fetch_seen = rd_en && fetch;
      cycles++;
    end
    if (!fetch_seen) abort_run("No instruction fetch after reset was released");
    else check_value("first fetch address", RESET_VECTOR, addr);

    // Branch-to-self fetched twice marks the end
    cycles = 0;
    end_hits = 0;
    while (end_hits < 2 && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      if (rd_en && fetch && addr == end_addr) end_hits++;
      cycles++;
    end
    if (end_hits < 2) begin
      abort_run("Program did not reach its final branch in time");
    end else begin
      check_value("number of writes", 32'(exp_addr.size()), 32'(wr_count));
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* logic/arm_core.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_core (
  input  logic                    clk,
  input  logic                    reset,
  input  arm_core_pkg::word_t     rdata,
  output arm_core_pkg::word_t     addr,
  output logic                    rd_en,
  output logic                    wr_en,
  output logic                    fetch,
  output arm_core_pkg::mem_size_e size,
  output arm_core_pkg::word_t     wdata
);
  import arm_core_pkg::*;

  word_t ir, addr_reg, link_data;
  logic link_pend;  // BL return address waits for the next fetch cycle

  instr_class_e instr_class;
  alu_op_e dec_op, alu_sel;
  reg_idx_t rn, rd, rm, ra, rb, wa;
  shift_type_e shift_type;
  logic [SHIFT_AMT_W-1:0] shift_amt;
  logic [ROT_IMM_W-1:0] rot_imm;
  mem_size_e mem_size;
  logic set_flags, imm_operand, load, up, signed_load, link, cond_pass;
  logic latch_ir, pc_inc, res_we, flags_we, addr_sel, mem_phase;
  logic is_dp, is_arith, rf_we;
  word_t offset, ra_data, rb_data, pc, b_in, alu_result, load_data, rf_wdata;
  flags_t flags, alu_flags, flags_in;

  assign is_dp = (instr_class == DATA_PROC);
  assign is_arith = dec_op inside {SUB, RSB, ADD, CMP};

  // ======================================================================
  // Bus selection
  // ======================================================================
  assign ra = (instr_class == BRANCH) ? PC_INDEX : rn;
  assign rb = is_dp ? rm : rd;  // Store data comes from Rd
  assign b_in = is_dp ? rb_data : offset;

  always_comb begin
    if (is_dp) alu_sel = dec_op;
    else if (instr_class == BRANCH) alu_sel = ADD;
    else alu_sel = up ? ADD : SUB;
  end

  // Logical ops leave V alone
  assign flags_in = is_arith ? alu_flags : {alu_flags[3:1], flags[FLAG_V]};

  // ======================================================================
  // Register write back
  // ======================================================================
  assign rf_we = link_pend || (res_we && !(is_dp && dec_op inside {TST, CMP}));

  always_comb begin
    if (link_pend) begin
      wa = LINK_INDEX;
      rf_wdata = link_data;
    end else begin
      wa = (instr_class == BRANCH) ? PC_INDEX : rd;
      rf_wdata = (load && mem_phase) ? load_data : alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      link_pend <= 1'b0;
    end else begin
      if (res_we && instr_class == BRANCH && link) link_pend <= 1'b1;
      else if (fetch) link_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (latch_ir) ir <= rdata;
    if (addr_sel) addr_reg <= alu_result;
    if (res_we) link_data <= ra_data - 32'd4;  // R15 + 8 less 4
  end

  assign addr = mem_phase ? addr_reg : pc;
  assign size = mem_phase ? mem_size : SIZE_WORD;

  always_comb begin
    unique case (mem_size)
      SIZE_BYTE: wdata = {24'd0, rb_data[7:0]};
      SIZE_HALF: wdata = {16'd0, rb_data[15:0]};
      default: wdata = rb_data;
    endcase
  end

  arm_decoder decoder_i (
    .ir(ir), .flags(flags), .instr_class(instr_class), .alu_op(dec_op),
    .rn(rn), .rd(rd), .rm(rm), .set_flags(set_flags), .imm_operand(imm_operand),
    .shift_type(shift_type), .shift_amt(shift_amt), .rot_imm(rot_imm), .load(load),
    .up(up), .mem_size(mem_size), .signed_load(signed_load), .offset(offset),
    .link(link), .cond_pass(cond_pass)
  );

  arm_control control_i (
    .clk(clk), .reset(reset), .instr_class(instr_class), .load(load),
    .set_flags(set_flags), .cond_pass(cond_pass), .rd_en(rd_en), .wr_en(wr_en),
    .fetch(fetch), .latch_ir(latch_ir), .pc_inc(pc_inc), .res_we(res_we),
    .flags_we(flags_we), .addr_sel(addr_sel), .mem_phase(mem_phase)
  );

  arm_alu_shifter alu_i (
    .a_bus(ra_data), .b_in(b_in), .imm_operand(imm_operand), .rot_imm(rot_imm),
    .shift_type(shift_type), .shift_amt(shift_amt), .alu_op(alu_sel),
    .carry_in(flags[FLAG_C]), .result(alu_result), .flags_out(alu_flags)
  );

  arm_load_align load_align_i (
    .rdata(rdata), .addr_low(addr_reg[1:0]), .mem_size(mem_size),
    .signed_load(signed_load), .load_data(load_data)
  );

  arm_regfile regfile_i (
    .clk(clk), .reset(reset), .ra(ra), .rb(rb), .we(rf_we), .wa(wa),
    .wdata(rf_wdata), .pc_inc(pc_inc), .flags_we(flags_we), .flags_in(flags_in),
    .ra_data(ra_data), .rb_data(rb_data), .pc(pc), .flags(flags)
  );

endmodule

`default_nettype wire

/* logic/arm_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  arm_core_pkg::reg_idx_t ra,
  input  arm_core_pkg::reg_idx_t rb,
  input  logic                   we,
  input  arm_core_pkg::reg_idx_t wa,
  input  arm_core_pkg::word_t    wdata,
  input  logic                   pc_inc,
  input  logic                   flags_we,
  input  arm_core_pkg::flags_t   flags_in,
  output arm_core_pkg::word_t    ra_data,
  output arm_core_pkg::word_t    rb_data,
  output arm_core_pkg::word_t    pc,
  output arm_core_pkg::flags_t   flags
);
  import arm_core_pkg::*;

  word_t regs [0:14];

  // PC already points past the fetch, so +4 gives address + 8
  assign ra_data = (ra == PC_INDEX) ? pc + 32'd4 : regs[ra];
  assign rb_data = (rb == PC_INDEX) ? pc + 32'd4 : regs[rb];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
      pc <= RESET_VECTOR;
      flags <= '0;
    end else begin
      if (we && wa == PC_INDEX) pc <= wdata;  // Branch wins over increment
      else if (pc_inc) pc <= pc + 32'd4;
      if (we && wa != PC_INDEX) regs[wa] <= wdata;
      if (flags_we) flags <= flags_in;
    end
  end

endmodule

`default_nettype wire

/* logic/arm_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_load_align (
  input  arm_core_pkg::word_t     rdata,
  input  logic [1:0]              addr_low,
  input  arm_core_pkg::mem_size_e mem_size,
  input  logic                    signed_load,
  output arm_core_pkg::word_t     load_data
);
  import arm_core_pkg::*;

  logic [63:0] dbl;
  word_t rot;  // Addressed byte lands in bits 7:0

  // Rotate right by 8 * addr_low; lanes and misaligned words share it
  assign dbl = {rdata, rdata} >> {addr_low, 3'b000};
  assign rot = dbl[31:0];

  always_comb begin
    unique case (mem_size)
      SIZE_BYTE: begin
        load_data = {24'd0, rot[7:0]};
        if (signed_load) load_data = {{24{rot[7]}}, rot[7:0]};
      end
      SIZE_HALF: begin
        if (!signed_load) load_data = {16'd0, rot[15:0]};
        else if (addr_low[0]) load_data = {{24{rot[7]}}, rot[7:0]};  // Odd LDRSH reads a byte
        else load_data = {{16{rot[15]}}, rot[15:0]};
      end
      default: load_data = rot;
    endcase
  end

endmodule

`default_nettype wire

/* logic/arm_alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_alu_shifter (
  input  arm_core_pkg::word_t                  a_bus,
  input  arm_core_pkg::word_t                  b_in,
  input  logic                                 imm_operand,
  input  logic [arm_core_pkg::ROT_IMM_W-1:0]   rot_imm,
  input  arm_core_pkg::shift_type_e            shift_type,
  input  logic [arm_core_pkg::SHIFT_AMT_W-1:0] shift_amt,
  input  arm_core_pkg::alu_op_e                alu_op,
  input  logic                                 carry_in,
  output arm_core_pkg::word_t                  result,
  output arm_core_pkg::flags_t                 flags_out
);
  import arm_core_pkg::*;

  function automatic word_t ror32(input word_t val, input logic [4:0] amt);
    logic [63:0] dbl;
    dbl = {val, val} >> amt;
    return dbl[31:0];
  endfunction

  word_t op2;
  logic shc;  // Shifter carry out
  logic [32:0] sh;
  logic [5:0] amt6;
  logic [4:0] rot;
  word_t x, y;
  logic cin, arith;
  logic [32:0] sum;

  // ======================================================================
  // Operand 2 shifter
  // ======================================================================
  always_comb begin
    rot = {rot_imm[11:8], 1'b0};
    amt6 = (shift_amt == '0) ? 6'd32 : {1'b0, shift_amt};
    sh = '0;
    op2 = b_in;
    shc = carry_in;
    if (imm_operand) begin
      op2 = ror32({24'd0, rot_imm[7:0]}, rot);
      if (rot != 5'd0) shc = op2[31];
    end else begin
      unique case (shift_type)
        LSL: if (shift_amt != '0) begin
          sh = {1'b0, b_in} << shift_amt;
          op2 = sh[31:0];
          shc = sh[32];
        end
        LSR: begin
          sh = {b_in, 1'b0} >> amt6;  // Bit 0 catches the last bit out
          op2 = sh[32:1];
          shc = sh[0];
        end
        ASR: begin
          sh = 33'($signed({b_in, 1'b0}) >>> amt6);
          op2 = sh[32:1];
          shc = sh[0];
        end
        ROR: if (shift_amt != '0) begin
          op2 = ror32(b_in, shift_amt);
          shc = op2[31];
        end
        default: ;
      endcase
    end
  end

  // ======================================================================
  // Adder and logic ops
  // ======================================================================
  always_comb begin
    x = a_bus;
    y = op2;
    cin = 1'b0;
    arith = 1'b1;
    unique case (alu_op)
      ADD: ;
      SUB, CMP: begin
        y = ~op2;
        cin = 1'b1;
      end
      RSB: begin
        x = op2;
        y = ~a_bus;
        cin = 1'b1;
      end
      default: arith = 1'b0;
    endcase
    sum = {1'b0, x} + {1'b0, y} + {32'd0, cin};

    unique case (alu_op)
      AND, TST: result = a_bus & op2;
      EOR: result = a_bus ^ op2;
      ORR: result = a_bus | op2;
      MOV: result = op2;
      MVN: result = ~op2;
      default: result = sum[31:0];
    endcase

    flags_out[FLAG_N] = result[31];
    flags_out[FLAG_Z] = (result == '0);
    flags_out[FLAG_C] = arith ? sum[32] : shc;
    flags_out[FLAG_V] = arith && (x[31] == y[31]) && (sum[31] != x[31]);
  end

endmodule

`default_nettype wire

/* logic/arm_control.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_control (
  input  logic                       clk,
  input  logic                       reset,
  input  arm_core_pkg::instr_class_e instr_class,
  input  logic                       load,
  input  logic                       set_flags,
  input  logic                       cond_pass,
  output logic                       rd_en,
  output logic                       wr_en,
  output logic                       fetch,
  output logic                       latch_ir,
  output logic                       pc_inc,
  output logic                       res_we,
  output logic                       flags_we,
  output logic                       addr_sel,
  output logic                       mem_phase
);
  import arm_core_pkg::*;

  core_state_e state, state_next;
  logic runs;  // Instruction executes at all
  logic is_mem;

  assign runs = cond_pass && (instr_class != NOP);
  assign is_mem = (instr_class == MEM_WORD) || (instr_class == MEM_HALF);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      FETCH: state_next = FETCH_WAIT;
      FETCH_WAIT: state_next = EXECUTE;
      EXECUTE: state_next = (runs && is_mem) ? MEM_REQ : FETCH;
      MEM_REQ: state_next = load ? MEM_WAIT : FETCH;
      MEM_WAIT: state_next = FETCH;
      default: state_next = FETCH;
    endcase
  end

  // ======================================================================
  // Strobes, decoded from the state
  // ======================================================================
  always_comb begin
    rd_en = 1'b0;
    wr_en = 1'b0;
    fetch = 1'b0;
    latch_ir = 1'b0;
    pc_inc = 1'b0;
    res_we = 1'b0;
    flags_we = 1'b0;
    addr_sel = 1'b0;
    mem_phase = 1'b0;

    unique case (state)
      FETCH: begin
        rd_en = 1'b1;
        fetch = 1'b1;
      end
      FETCH_WAIT: begin
        latch_ir = 1'b1;
        pc_inc = 1'b1;
      end
      EXECUTE: begin
        res_we = runs && !is_mem;  // DP result or branch target
        flags_we = runs && set_flags;
        addr_sel = runs && is_mem;  // Capture transfer address
      end
      MEM_REQ: begin
        mem_phase = 1'b1;
        rd_en = load;
        wr_en = !load;
      end
      MEM_WAIT: begin
        mem_phase = 1'b1;
        res_we = 1'b1;  // Load data returns this cycle
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/arm_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_decoder (
  input  arm_core_pkg::word_t                        ir,
  input  arm_core_pkg::flags_t                       flags,
  output arm_core_pkg::instr_class_e                 instr_class,
  output arm_core_pkg::alu_op_e                      alu_op,
  output arm_core_pkg::reg_idx_t                     rn,
  output arm_core_pkg::reg_idx_t                     rd,
  output arm_core_pkg::reg_idx_t                     rm,
  output logic                                       set_flags,
  output logic                                       imm_operand,
  output arm_core_pkg::shift_type_e                  shift_type,
  output logic [arm_core_pkg::SHIFT_AMT_W-1:0]       shift_amt,
  output logic [arm_core_pkg::ROT_IMM_W-1:0]         rot_imm,
  output logic                                       load,
  output logic                                       up,
  output arm_core_pkg::mem_size_e                    mem_size,
  output logic                                       signed_load,
  output arm_core_pkg::word_t                        offset,
  output logic                                       link,
  output logic                                       cond_pass
);
  import arm_core_pkg::*;

  logic is_dp, is_word, is_half, is_branch;
  logic n, z, c, v;

  assign {n, z, c, v} = {flags[FLAG_N], flags[FLAG_Z], flags[FLAG_C], flags[FLAG_V]};

  // Only the supported opcodes; TST and CMP need S, else it is a misc encoding
  assign is_dp = (ir[27:26] == 2'b00) && (ir[25] || !ir[4]) &&
                 ((ir[24:21] inside {4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'hC, 4'hD, 4'hF}) ||
                  ((ir[24:21] inside {4'h8, 4'hA}) && ir[20]));
  assign is_word = (ir[27:25] == 3'b010) && ir[24] && !ir[21];  // Imm offset, pre, no WB
  assign is_half = (ir[27:25] == 3'b000) && ir[24] && ir[22] && !ir[21] && ir[7] && ir[4] &&
                   (ir[6:5] != 2'b00) && (ir[20] || ir[6:5] == 2'b01);
  assign is_branch = (ir[27:25] == 3'b101);

  always_comb begin
    if (is_dp) instr_class = DATA_PROC;
    else if (is_word) instr_class = MEM_WORD;
    else if (is_half) instr_class = MEM_HALF;
    else if (is_branch) instr_class = BRANCH;
    else instr_class = NOP;
  end

  assign alu_op = alu_op_e'(ir[24:21]);
  assign rn = ir[19:16];
  assign rd = ir[15:12];
  assign rm = ir[3:0];
  assign set_flags = is_dp && ir[20];

  // Non-DP classes pass the offset through the shifter unchanged
  assign imm_operand = is_dp && ir[25];
  assign shift_type = is_dp ? shift_type_e'(ir[6:5]) : LSL;
  assign shift_amt = is_dp ? ir[11:7] : '0;
  assign rot_imm = ir[11:0];

  assign load = (is_word || is_half) && ir[20];
  assign up = ir[23];
  assign signed_load = is_half && ir[6];
  assign link = is_branch && ir[24];

  always_comb begin
    if (is_half) mem_size = (ir[6:5] == 2'b10) ? SIZE_BYTE : SIZE_HALF;
    else mem_size = ir[22] ? SIZE_BYTE : SIZE_WORD;
  end

  always_comb begin
    if (is_branch) offset = {{6{ir[23]}}, ir[23:0], 2'b00};
    else if (is_half) offset = {24'd0, ir[11:8], ir[3:0]};
    else offset = {20'd0, ir[11:0]};
  end

  // ======================================================================
  // Condition field
  // ======================================================================
  always_comb begin
    unique case (ir[31:28])
      4'h0: cond_pass = z;             // EQ
      4'h1: cond_pass = !z;            // NE
      4'h2: cond_pass = c;             // CS
      4'h3: cond_pass = !c;            // CC
      4'h4: cond_pass = n;             // MI
      4'h5: cond_pass = !n;            // PL
      4'h6: cond_pass = v;             // VS
      4'h7: cond_pass = !v;            // VC
      4'h8: cond_pass = c && !z;       // HI
      4'h9: cond_pass = !c || z;       // LS
      4'hA: cond_pass = (n == v);      // GE
      4'hB: cond_pass = (n != v);      // LT
      4'hC: cond_pass = !z && (n == v);
      4'hD: cond_pass = z || (n != v);
      4'hE: cond_pass = 1'b1;          // AL
      default: cond_pass = 1'b0;       // NV never executes
    endcase
  end

endmodule

`default_nettype wire

/* logic/arm_core_pkg.sv */
`default_nettype none

package arm_core_pkg;

  // ======================================================================
  // Basic types
  // ======================================================================
  typedef logic [31:0] word_t;
  typedef logic [3:0] reg_idx_t;
  typedef logic [3:0] flags_t;  // {N, Z, C, V}

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  localparam int SHIFT_AMT_W = 5;
  localparam int ROT_IMM_W = 12;

  localparam reg_idx_t PC_INDEX = 4'd15;
  localparam reg_idx_t LINK_INDEX = 4'd14;
  localparam word_t RESET_VECTOR = 32'h0000_0000;

  // ======================================================================
  // Decode and control enums
  // ======================================================================
  typedef enum logic [2:0] {
    DATA_PROC,
    MEM_WORD,
    MEM_HALF,
    BRANCH,
    NOP
  } instr_class_e;

  // Values match the ARM opcode field [24:21]
  typedef enum logic [3:0] {
    AND = 4'h0,
    EOR = 4'h1,
    SUB = 4'h2,
    RSB = 4'h3,
    ADD = 4'h4,
    TST = 4'h8,
    CMP = 4'hA,
    ORR = 4'hC,
    MOV = 4'hD,
    MVN = 4'hF
  } alu_op_e;

  // Immediate shift amount of 0 means 32 for LSR and ASR.
  // ROR by 0 passes the operand through and keeps C (no RRX).
  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shift_type_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_WAIT,
    EXECUTE,
    MEM_REQ,
    MEM_WAIT
  } core_state_e;

endpackage

`default_nettype wire
